// File: src/pcore_bus_pkg.sv
/* Data bus types and peripheral memory map.
   Word accesses only, no byte enables. Regions are 64 KiB aligned. */
package pcore_bus_pkg;

    // Bus data word and byte address
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // ------------------------------------------------------------------
    // Memory map
    // ------------------------------------------------------------------

    // Lowest address bit that the decoder compares
    localparam int unsigned REGION_LSB = 16;

    // Core-level interruptor
    localparam addr_t CLINT_BASE = 32'h0200_0000;

    // Scratch word memory
    localparam addr_t SMEM_BASE = 32'h1000_0000;

    // ------------------------------------------------------------------
    // Scratch memory geometry
    // ------------------------------------------------------------------

    // Size in 32-bit words
    localparam int unsigned SMEM_DEPTH = 64;

    // Word index width, taken from address bit 2 upward
    localparam int unsigned SMEM_IDX_W = $clog2(SMEM_DEPTH);

endpackage

// File: src/clint_pkg.sv
/* Register map of the machine timer block.
   Only mtime and mtimecmp exist. There is no msip register. */
package clint_pkg;

    // Offset bits decoded inside the timer region
    localparam int unsigned CLINT_OFF_W = 4;

    // 64-bit timer and compare value
    typedef logic [63:0] mtime_t;

    // Register offset inside the region
    typedef logic [CLINT_OFF_W-1:0] clint_off_t;

    // ------------------------------------------------------------------
    // Register byte offsets
    // ------------------------------------------------------------------

    // Free-running timer, low and high words
    localparam clint_off_t MTIME_LO    = 4'h0;
    localparam clint_off_t MTIME_HI    = 4'h4;

    // Compare value, low and high words
    localparam clint_off_t MTIMECMP_LO = 4'h8;
    localparam clint_off_t MTIMECMP_HI = 4'hC;

    // ------------------------------------------------------------------
    // Reset values
    // ------------------------------------------------------------------

    // All ones keeps the timer interrupt off until software sets a compare
    localparam mtime_t MTIMECMP_RST = {64{1'b1}};

endpackage

// File: src/dbus_decoder.sv
`timescale 1ns/100ps

/* Selects are plain address decodes and ignore cyc.
   Unmapped accesses get a zero-data ack one cycle after the request. */
module dbus_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dbus_cyc_i,
    input  logic                 dbus_w_en_i,
    input  pcore_bus_pkg::addr_t dbus_addr_i,
    output logic                 clint_sel_o,
    output logic                 smem_sel_o,
    input  pcore_bus_pkg::word_t clint_r_data_i,
    input  pcore_bus_pkg::word_t smem_r_data_i,
    input  logic                 clint_ack_i,
    input  logic                 smem_ack_i,
    output pcore_bus_pkg::word_t dbus_r_data_o,
    output logic                 dbus_ack_o
);
    import pcore_bus_pkg::*;

    // No region matched
    logic unmapped;

    // Delayed ack of the default responder
    logic dflt_ack_ff;

    // ------------------------------------------------------------------
    // Region decode
    // ------------------------------------------------------------------
    assign clint_sel_o = (dbus_addr_i[31:REGION_LSB] == CLINT_BASE[31:REGION_LSB]);
    assign smem_sel_o  = (dbus_addr_i[31:REGION_LSB] == SMEM_BASE[31:REGION_LSB]);
    assign unmapped    = !clint_sel_o && !smem_sel_o;

    // Default responder
    // One-cycle ack, then low for a cycle if the master keeps cyc up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dflt_ack_ff <= 1'b0;
        end else begin
            dflt_ack_ff <= dbus_cyc_i && unmapped && !dflt_ack_ff;
        end
    end

    // ------------------------------------------------------------------
    // Response steering
    // ------------------------------------------------------------------
    // Master holds the address until ack, so the current select
    // still points at the peripheral that is answering
    always_comb begin
        if (clint_sel_o) begin
            dbus_r_data_o = clint_r_data_i;
            dbus_ack_o    = clint_ack_i;
        end else if (smem_sel_o) begin
            dbus_r_data_o = smem_r_data_i;
            dbus_ack_o    = smem_ack_i;
        end else begin
            dbus_r_data_o = '0;
            dbus_ack_o    = dflt_ack_ff;
        end
    end

    // Overlapping bases
    sel_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(clint_sel_o && smem_sel_o));

    // Mapped writes answered by the peripheral in the request cycle
    mapped_wr_ack: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_cyc_i && dbus_w_en_i && !unmapped |-> dbus_ack_o);

endmodule

// File: src/clint.sv
`timescale 1ns/100ps

/* Machine timer with 64-bit mtime and mtimecmp, word access only.
   A half write replaces that half and skips the increment for one cycle. */
module clint (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clint_sel_i,
    input  logic                 dbus_cyc_i,
    input  logic                 dbus_w_en_i,
    input  pcore_bus_pkg::addr_t dbus_addr_i,
    input  pcore_bus_pkg::word_t dbus_w_data_i,
    output pcore_bus_pkg::word_t clint_r_data_o,
    output logic                 clint_ack_o,
    output logic                 clint_timer_irq_o
);
    import pcore_bus_pkg::*;
    import clint_pkg::*;

    // Bus request decode
    clint_off_t addr_offset;
    logic       r_req;
    logic       w_req;

    // Register state
    mtime_t mtime_ff, mtime_next;
    mtime_t mtimecmp_ff, mtimecmp_next;

    // Per-half write strobes
    logic mtime_lo_wr;
    logic mtime_hi_wr;
    logic mtimecmp_lo_wr;
    logic mtimecmp_hi_wr;

    // Read mux and registered response
    word_t r_data;
    word_t r_data_ff;
    logic  r_ack_ff;

    logic irq_ff;

    assign addr_offset = dbus_addr_i[CLINT_OFF_W-1:0];
    assign r_req       = clint_sel_i && dbus_cyc_i && !dbus_w_en_i;
    assign w_req       = clint_sel_i && dbus_cyc_i && dbus_w_en_i;

    // ------------------------------------------------------------------
    // Register decode
    // ------------------------------------------------------------------
    always_comb begin
        r_data = '0;
        case (addr_offset)
            MTIME_LO:    r_data = mtime_ff[31:0];
            MTIME_HI:    r_data = mtime_ff[63:32];
            MTIMECMP_LO: r_data = mtimecmp_ff[31:0];
            MTIMECMP_HI: r_data = mtimecmp_ff[63:32];
            default:     r_data = '0;
        endcase
    end

    // Unused offsets ignore writes
    assign mtime_lo_wr    = w_req && (addr_offset == MTIME_LO);
    assign mtime_hi_wr    = w_req && (addr_offset == MTIME_HI);
    assign mtimecmp_lo_wr = w_req && (addr_offset == MTIMECMP_LO);
    assign mtimecmp_hi_wr = w_req && (addr_offset == MTIMECMP_HI);

    // ------------------------------------------------------------------
    // Timer and compare registers
    // ------------------------------------------------------------------
    always_comb begin
        mtime_next = mtime_ff + 64'd1;
        if (mtime_lo_wr) begin
            mtime_next = {mtime_ff[63:32], dbus_w_data_i};
        end else if (mtime_hi_wr) begin
            mtime_next = {dbus_w_data_i, mtime_ff[31:0]};
        end

        mtimecmp_next = mtimecmp_ff;
        if (mtimecmp_lo_wr) begin
            mtimecmp_next = {mtimecmp_ff[63:32], dbus_w_data_i};
        end else if (mtimecmp_hi_wr) begin
            mtimecmp_next = {dbus_w_data_i, mtimecmp_ff[31:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_ff    <= '0;
            mtimecmp_ff <= MTIMECMP_RST;
            irq_ff      <= 1'b0;
        end else begin
            mtime_ff    <= mtime_next;
            mtimecmp_ff <= mtimecmp_next;
            // Level interrupt, follows the compare one cycle late
            irq_ff      <= (mtime_ff >= mtimecmp_ff);
        end
    end

    // ------------------------------------------------------------------
    // Bus response
    // ------------------------------------------------------------------
    // Read data sampled at the first request edge
    // A held read is answered every second cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_ack_ff  <= 1'b0;
            r_data_ff <= '0;
        end else begin
            r_ack_ff <= r_req && !r_ack_ff;
            if (r_req && !r_ack_ff) begin
                r_data_ff <= r_data;
            end
        end
    end

    assign clint_r_data_o    = r_data_ff;
    assign clint_ack_o       = w_req || r_ack_ff;
    assign clint_timer_irq_o = irq_ff;

    wr_flags_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({mtime_lo_wr, mtime_hi_wr, mtimecmp_lo_wr, mtimecmp_hi_wr}));

    // Ack only while or right after a request
    ack_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        clint_ack_o |-> (dbus_cyc_i || $past(dbus_cyc_i)));

endmodule

// File: src/scratch_mem.sv
`timescale 1ns/100ps

/* Word memory indexed by address bits above bit 1; upper bits alias.
   Write ack in the request cycle, read ack and data one cycle later. */
module scratch_mem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 smem_sel_i,
    input  logic                 dbus_cyc_i,
    input  logic                 dbus_w_en_i,
    input  pcore_bus_pkg::addr_t dbus_addr_i,
    input  pcore_bus_pkg::word_t dbus_w_data_i,
    output pcore_bus_pkg::word_t smem_r_data_o,
    output logic                 smem_ack_o
);
    import pcore_bus_pkg::*;

    // Storage
    word_t mem [SMEM_DEPTH];

    logic [SMEM_IDX_W-1:0] idx;
    logic                  r_req;
    logic                  w_req;

    // Registered read response
    word_t r_data_ff;
    logic  r_ack_ff;

    assign idx   = dbus_addr_i[2 +: SMEM_IDX_W];
    assign r_req = smem_sel_i && dbus_cyc_i && !dbus_w_en_i;
    assign w_req = smem_sel_i && dbus_cyc_i && dbus_w_en_i;

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (w_req) begin
            mem[idx] <= dbus_w_data_i;
        end
    end

    // ------------------------------------------------------------------
    // Read port, same timing as the timer block
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_ack_ff  <= 1'b0;
            r_data_ff <= '0;
        end else begin
            r_ack_ff <= r_req && !r_ack_ff;
            if (r_req && !r_ack_ff) begin
                r_data_ff <= mem[idx];
            end
        end
    end

    assign smem_r_data_o = r_data_ff;
    assign smem_ack_o    = w_req || r_ack_ff;

    // Held read gets a gap cycle after each ack
    held_rd_gap: assert property (@(posedge clk) disable iff (!rst_n)
        r_req && smem_ack_o |=> !smem_ack_o);

endmodule

// File: src/peri_subsys_top.sv
`timescale 1ns/100ps

/* Peripheral corner of the data bus: decoder, timer and scratch memory.
   One master; the master must hold a request until it sees ack. */
module peri_subsys_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dbus_cyc_i,
    input  logic                 dbus_w_en_i,
    input  pcore_bus_pkg::addr_t dbus_addr_i,
    input  pcore_bus_pkg::word_t dbus_w_data_i,
    output pcore_bus_pkg::word_t dbus_r_data_o,
    output logic                 dbus_ack_o,
    output logic                 timer_irq_o
);
    import pcore_bus_pkg::*;

    // Region selects
    logic  clint_sel;
    logic  smem_sel;

    // Peripheral responses
    word_t clint_r_data;
    word_t smem_r_data;
    logic  clint_ack;
    logic  smem_ack;

    dbus_decoder u_dbus_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .dbus_cyc_i    (dbus_cyc_i),
        .dbus_w_en_i   (dbus_w_en_i),
        .dbus_addr_i   (dbus_addr_i),
        .clint_sel_o   (clint_sel),
        .smem_sel_o    (smem_sel),
        .clint_r_data_i(clint_r_data),
        .smem_r_data_i (smem_r_data),
        .clint_ack_i   (clint_ack),
        .smem_ack_i    (smem_ack),
        .dbus_r_data_o (dbus_r_data_o),
        .dbus_ack_o    (dbus_ack_o)
    );

    // Timer interrupt goes straight out
    clint u_clint (
        .clk              (clk),
        .rst_n            (rst_n),
        .clint_sel_i      (clint_sel),
        .dbus_cyc_i       (dbus_cyc_i),
        .dbus_w_en_i      (dbus_w_en_i),
        .dbus_addr_i      (dbus_addr_i),
        .dbus_w_data_i    (dbus_w_data_i),
        .clint_r_data_o   (clint_r_data),
        .clint_ack_o      (clint_ack),
        .clint_timer_irq_o(timer_irq_o)
    );

    scratch_mem u_scratch_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .smem_sel_i   (smem_sel),
        .dbus_cyc_i   (dbus_cyc_i),
        .dbus_w_en_i  (dbus_w_en_i),
        .dbus_addr_i  (dbus_addr_i),
        .dbus_w_data_i(dbus_w_data_i),
        .smem_r_data_o(smem_r_data),
        .smem_ack_o   (smem_ack)
    );

endmodule

// File: testbench/peri_subsys_tb.sv
`timescale 1ns/100ps

/* Bus master testbench, reads testbench/peri_subsys_trace.txt from the project root.
   Timer reads and the interrupt are predicted by a local 64-bit timer model. */
module peri_subsys_tb;
    import pcore_bus_pkg::*;
    import clint_pkg::*;

    localparam int unsigned TRACE_W   = 8;
    localparam int unsigned MAX_OPS   = (2 ** TRACE_W) / 4;
    localparam int unsigned ACK_LIMIT = 4;
    localparam int unsigned MARGIN    = 50;

    logic  clk;
    logic  rst_n;
    logic  dbus_cyc;
    logic  dbus_w_en;
    addr_t dbus_addr;
    word_t dbus_w_data;
    word_t dbus_r_data;
    logic  dbus_ack;
    logic  timer_irq;

    // Four words per operation, kind 0 ends the trace
    word_t trace [0:2**TRACE_W-1];

    // Timer model
    mtime_t mtime_model;
    mtime_t cmp_model;
    logic   irq_model;

    // Random scratch data by address
    word_t       rand_data [addr_t];
    integer      seed = 32'hbe97_0aea;
    int unsigned errors = 0;
    int unsigned cycles = 0;
    int unsigned cycle_limit = 0;

    peri_subsys_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .dbus_cyc_i   (dbus_cyc),
        .dbus_w_en_i  (dbus_w_en),
        .dbus_addr_i  (dbus_addr),
        .dbus_w_data_i(dbus_w_data),
        .dbus_r_data_o(dbus_r_data),
        .dbus_ack_o   (dbus_ack),
        .timer_irq_o  (timer_irq)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic word_t trace_field(input int unsigned op, input int unsigned k);
        return trace[TRACE_W'(4 * op + k)];
    endfunction

    function automatic logic is_timer_write(input clint_off_t off);
        return dbus_cyc && dbus_w_en && (dbus_addr == (CLINT_BASE | addr_t'(off)));
    endfunction

    // ------------------------------------------------------------------
    // Timer model
    // ------------------------------------------------------------------
    // Counts every edge; a written half loads and the count skips
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_model <= '0;
            cmp_model   <= MTIMECMP_RST;
            irq_model   <= 1'b0;
        end else begin
            irq_model <= (mtime_model >= cmp_model);
            if (is_timer_write(MTIME_LO)) begin
                mtime_model[31:0] <= dbus_w_data;
            end else if (is_timer_write(MTIME_HI)) begin
                mtime_model[63:32] <= dbus_w_data;
            end else begin
                mtime_model <= mtime_model + 64'd1;
            end
            if (is_timer_write(MTIMECMP_LO)) begin
                cmp_model[31:0] <= dbus_w_data;
            end else if (is_timer_write(MTIMECMP_HI)) begin
                cmp_model[63:32] <= dbus_w_data;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Run stopped at cycle %0d before the trace ended, %0d errors",
                     cycles, errors);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_irq(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected irq %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------
    // Bus master
    // ------------------------------------------------------------------
    // Starts on a rising edge, holds until ack, then one idle cycle
    task automatic bus_access(input logic we, input addr_t a, input word_t wd,
                              output word_t rd, output mtime_t t_req);
        int unsigned n;
        n           = 0;
        rd          = '0;
        dbus_cyc    <= 1'b1;
        dbus_w_en   <= we;
        dbus_addr   <= a;
        dbus_w_data <= wd;
        @(negedge clk);
        // Timer value that the first request edge sees
        t_req = mtime_model;
        while (!dbus_ack && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (dbus_ack) begin
            rd = dbus_r_data;
        end else begin
            $display("Bus access to %h got no ack within %0d cycles", a, ACK_LIMIT);
            errors++;
        end
        @(posedge clk);
        dbus_cyc <= 1'b0;
        @(posedge clk);
    endtask

    // Model check every cycle; a 0 or 1 in the trace also pins the last one
    task automatic wait_and_check_irq(input string name, input word_t n, input word_t exp);
        for (int unsigned i = 1; i <= n; i++) begin
            @(negedge clk);
            check_irq(name, irq_model, timer_irq);
            if (i == n && exp <= 32'd1) begin
                check_irq(name, exp[0], timer_irq);
            end
            @(posedge clk);
        end
    endtask

    initial begin
        word_t       kind;
        word_t       addr;
        word_t       data;
        word_t       exp;
        word_t       rd;
        mtime_t      t_req;
        mtime_t      target;
        string       name;
        int unsigned op;
        rst_n       = 1'b0;
        dbus_cyc    = 1'b0;
        dbus_w_en   = 1'b0;
        dbus_addr   = '0;
        dbus_w_data = '0;
        foreach (trace[i]) begin
            trace[i] = '0;
        end
        $readmemh("testbench/peri_subsys_trace.txt", trace);

        // Waits as given, any other operation within 8 cycles
        // Two closing compare reads follow the trace
        cycle_limit = 4 + 2 * 8 + MARGIN;
        for (op = 0; op < MAX_OPS && trace_field(op, 0) != '0; op++) begin
            cycle_limit += (trace_field(op, 0) == 32'd4) ? trace_field(op, 2) : 32'd8;
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_irq("irq after reset", 1'b0, timer_irq);
        if (dbus_ack !== 1'b0) begin
            $display("dbus_ack_o is high after reset with no request");
            errors++;
        end
        @(posedge clk);

        for (op = 0; op < MAX_OPS && trace_field(op, 0) != '0; op++) begin
            kind = trace_field(op, 0);
            addr = trace_field(op, 1);
            data = trace_field(op, 2);
            exp  = trace_field(op, 3);
            name = $sformatf("op %0d kind %0d at %h", op + 1, kind, addr);
            case (kind)
                32'd1: bus_access(1'b1, addr, data, rd, t_req);
                32'd2: begin
                    bus_access(1'b0, addr, '0, rd, t_req);
                    check_word(name, exp, rd);
                end
                32'd3: begin
                    bus_access(1'b0, addr, '0, rd, t_req);
                    if (addr[CLINT_OFF_W-1:0] == MTIME_HI) begin
                        check_word(name, t_req[63:32], rd);
                    end else begin
                        check_word(name, t_req[31:0], rd);
                    end
                end
                32'd4: wait_and_check_irq(name, data, exp);
                32'd5: begin
                    rand_data[addr] = $random(seed);
                    bus_access(1'b1, addr, rand_data[addr], rd, t_req);
                end
                32'd6: begin
                    bus_access(1'b0, addr, '0, rd, t_req);
                    check_word(name, rand_data[addr], rd);
                end
                32'd7: begin
                    // Zero offset picks a random one from 8 to 15
                    if (data == '0) begin
                        data = 32'd8 + ($unsigned($random(seed)) % 32'd8);
                    end
                    target = mtime_model + mtime_t'(data);
                    bus_access(1'b1, CLINT_BASE | addr_t'(MTIMECMP_HI), target[63:32], rd, t_req);
                    bus_access(1'b1, CLINT_BASE | addr_t'(MTIMECMP_LO), target[31:0], rd, t_req);
                end
                default: begin
                    $display("Trace operation %0d has unknown kind %0d", op + 1, kind);
                    errors++;
                end
            endcase
        end

        // Both compare halves against the model, so aliased writes show up
        bus_access(1'b0, CLINT_BASE | addr_t'(MTIMECMP_LO), '0, rd, t_req);
        check_word("mtimecmp low at end", cmp_model[31:0], rd);
        bus_access(1'b0, CLINT_BASE | addr_t'(MTIMECMP_HI), '0, rd, t_req);
        check_word("mtimecmp high at end", cmp_model[63:32], rd);

        $display("Trace done after %0d operations, %0d errors", op, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: testbench/peri_subsys_trace.txt
// Columns in hex: kind address data expected. Kinds: 1 write, 2 read and compare,
// 3 timer read, 4 wait data cycles with irq expected (2 = model only), 5 random write,
// 6 read of random data, 7 mtimecmp = mtime + data (0 = random offset)
2 02000008 00000000 ffffffff
2 0200000c 00000000 ffffffff
1 10000000 cafe0001 00000000
1 10000004 12345678 00000000
5 10000008 00000000 00000000
5 100000fc 00000000 00000000
1 10000004 a5a5a5a5 00000000
2 10000000 00000000 cafe0001
2 10000004 00000000 a5a5a5a5
6 10000008 00000000 00000000
6 100000fc 00000000 00000000
1 02000004 00000001 00000000
1 02000000 fffffff8 00000000
4 00000000 0000000c 00000000
3 02000004 00000000 00000000
3 02000000 00000000 00000000
7 00000000 00000010 00000000
4 00000000 00000020 00000001
7 00000000 00000000 00000000
4 00000000 00000020 00000001
1 0200000c ffffffff 00000000
4 00000000 00000003 00000000
2 30000000 00000000 00000000
1 30000008 deadbeef 00000000
1 02010008 00000000 00000000
6 10000008 00000000 00000000
2 10000000 00000000 cafe0001
2 0200000c 00000000 ffffffff

// File: filelist.f
src/pcore_bus_pkg.sv
src/clint_pkg.sv
src/dbus_decoder.sv
src/clint.sv
src/scratch_mem.sv
src/peri_subsys_top.sv
testbench/peri_subsys_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = peri_subsys_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf $(OBJ_DIR)
